//--- compile.f
verilog/mmio_pkg.sv
verilog/mmio_master.sv
verilog/mmio_decode.sv
verilog/mmio_execute.sv
verilog/mmio_result.sv
verilog/mmio_top.sv
tb/mmio_assertions.sv
tb/mmio_checker.sv
tb/tb_mmio.sv

//--- run.sh
#!/bin/sh
# Build the MMIO testbench with Verilator, run it and judge the log.

cd "$(dirname "$0")" || exit 1

OBJ_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert \
  --top-module tb_mmio \
  -Mdir "$OBJ_DIR" -o Vtb_mmio \
  -f compile.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$OBJ_DIR/Vtb_mmio" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Test failures found" "$LOG"; then
  echo "FAIL"
  exit 1
fi

echo "PASS"
exit 0

//--- tb/mmio_assertions.sv
// Bound assertions: AXI-lite valid stability, paired aw and w raise, host read strobe rule, failure count.
`timescale 1ns/1ps

module mmio_assertions (
  input logic                        clk,
  input logic                        rst,
  input logic                        arvalid,
  input logic                        arready,
  input logic [mmio_pkg::addr_w-1:0] araddr,
  input logic                        awvalid,
  input logic                        awready,
  input logic [mmio_pkg::addr_w-1:0] awaddr,
  input logic                        wvalid,
  input logic                        wready,
  input logic [mmio_pkg::data_w-1:0] wdata,
  input logic                        rd_req,
  input logic                        rd_busy
);

  // Number of failed assertions so far.
  int fail_count = 0;

  // A valid without its ready holds and keeps its payload.
  ar_hold: assert property (@(posedge clk) disable iff (rst)
    arvalid && !arready |=> arvalid && $stable(araddr))
    else begin
      $error("arvalid dropped or araddr changed before arready");
      fail_count++;
    end

  aw_hold: assert property (@(posedge clk) disable iff (rst)
    awvalid && !awready |=> awvalid && $stable(awaddr))
    else begin
      $error("awvalid dropped or awaddr changed before awready");
      fail_count++;
    end

  w_hold: assert property (@(posedge clk) disable iff (rst)
    wvalid && !wready |=> wvalid && $stable(wdata))
    else begin
      $error("wvalid dropped or wdata changed before wready");
      fail_count++;
    end

  // Address and data of a write start in the same cycle.
  aw_w_pair: assert property (@(posedge clk) disable iff (rst)
    $rose(awvalid) == $rose(wvalid))
    else begin
      $error("awvalid and wvalid did not rise together");
      fail_count++;
    end

  // The host never strobes a read into a busy channel.
  rd_req_idle: assert property (@(posedge clk) disable iff (rst)
    rd_busy |-> !rd_req)
    else begin
      $error("rd_req given while rd_busy was high");
      fail_count++;
    end

endmodule

//--- tb/mmio_checker.sv
// Testbench checker: register reference model, expected response queues and done pulse compare.
`timescale 1ns/1ps

module mmio_checker (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        rd_req,
  input  logic [mmio_pkg::addr_w-1:0] rd_addr,
  input  logic                        rd_busy,
  input  logic                        rd_done,
  input  logic [mmio_pkg::data_w-1:0] rd_data,
  input  logic [mmio_pkg::resp_w-1:0] rd_resp,
  input  logic                        wr_req,
  input  logic [mmio_pkg::addr_w-1:0] wr_addr,
  input  logic [mmio_pkg::data_w-1:0] wr_data,
  input  logic                        wr_busy,
  input  logic                        wr_done,
  input  logic [mmio_pkg::resp_w-1:0] wr_resp,
  output int                          err_count,
  output int                          reads_checked,
  output int                          writes_checked,
  output int                          pending
);

  import mmio_pkg::*;

  // Model of the writable state.
  logic [data_w-1:0] scratch0_m;
  logic [data_w-1:0] scratch1_m;
  logic [data_w-1:0] count_m;

  // Expected responses in issue order.
  logic [addr_w-1:0] rd_addr_q[$];
  logic [data_w-1:0] rd_data_q[$];
  logic [resp_w-1:0] rd_resp_q[$];
  logic [resp_w-1:0] wr_resp_q[$];

  // Only 8-byte aligned addresses below 0x20 hit a register.
  function automatic logic mapped(input logic [addr_w-1:0] a);
    return (a[2:0] == 3'd0) && (a[addr_w-1:5] == '0);
  endfunction

  initial begin
    err_count      = 0;
    reads_checked  = 0;
    writes_checked = 0;
    pending        = 0;
  end

  always @(posedge clk) begin : check_edge
    logic [addr_w-1:0] exp_addr;
    logic [data_w-1:0] exp_data;
    logic [resp_w-1:0] exp_resp;
    if (rst) begin
      scratch0_m = '0;
      scratch1_m = '0;
      count_m    = '0;
      rd_addr_q.delete();
      rd_data_q.delete();
      rd_resp_q.delete();
      wr_resp_q.delete();
    end else begin
      // Completions first.
      if (rd_done) begin
        if (rd_data_q.size() == 0) begin
          $display("Error at %0t: read completed with no read outstanding", $time);
          err_count++;
        end else begin
          exp_addr = rd_addr_q.pop_front();
          exp_data = rd_data_q.pop_front();
          exp_resp = rd_resp_q.pop_front();
          if (rd_data !== exp_data || rd_resp !== exp_resp) begin
            $display("Fail at %0t: read of %h gave %h resp %0d, expected %h resp %0d",
                     $time, exp_addr, rd_data, rd_resp, exp_data, exp_resp);
            err_count++;
          end
          reads_checked++;
        end
      end
      if (wr_done) begin
        if (wr_resp_q.size() == 0) begin
          $display("Error at %0t: write completed with no write outstanding", $time);
          err_count++;
        end else begin
          exp_resp = wr_resp_q.pop_front();
          if (wr_resp !== exp_resp) begin
            $display("Fail at %0t: write gave resp %0d, expected %0d", $time, wr_resp, exp_resp);
            err_count++;
          end
          writes_checked++;
        end
      end
      // A read sees the registers from before a write issued on the same edge.
      if (rd_req && !rd_busy) begin
        rd_addr_q.push_back(rd_addr);
        if (!mapped(rd_addr)) begin
          rd_data_q.push_back('0);
          rd_resp_q.push_back(resp_decerr);
        end else begin
          case (rd_addr[4:3])
            2'd0:    rd_data_q.push_back(id_value);
            2'd1:    rd_data_q.push_back(scratch0_m);
            2'd2:    rd_data_q.push_back(scratch1_m);
            default: rd_data_q.push_back(count_m);
          endcase
          rd_resp_q.push_back(resp_okay);
        end
      end
      if (wr_req && !wr_busy) begin
        if (!mapped(wr_addr))
          wr_resp_q.push_back(resp_decerr);
        else if (wr_addr[4:3] == 2'd0 || wr_addr[4:3] == 2'd3)
          wr_resp_q.push_back(resp_slverr);
        else begin
          wr_resp_q.push_back(resp_okay);
          if (wr_addr[4:3] == 2'd1)
            scratch0_m = wr_data;
          else
            scratch1_m = wr_data;
          count_m = count_m + 64'd1;
        end
      end
    end
    pending = rd_data_q.size() + wr_resp_q.size();
  end

endmodule

//--- tb/tb_mmio.sv
// Testbench top: clock, reset, LCG stimulus, DUT, checker, assertion bind and closing report.
`timescale 1ns/1ps

module tb_mmio;

  import mmio_pkg::*;

  // Limits in clock cycles and command counts.
  localparam int op_limit  = 40;
  localparam int mix_total = 300;
  localparam int mix_limit = 10000;

  logic              clk;
  logic              rst;
  logic              rd_req;
  logic [addr_w-1:0] rd_addr;
  logic              rd_busy;
  logic              rd_done;
  logic [data_w-1:0] rd_data;
  logic [resp_w-1:0] rd_resp;
  logic              wr_req;
  logic [addr_w-1:0] wr_addr;
  logic [data_w-1:0] wr_data;
  logic              wr_busy;
  logic              wr_done;
  logic [resp_w-1:0] wr_resp;

  int          err_count;
  int          reads_checked;
  int          writes_checked;
  int          pending;
  int          timeouts;
  int          assert_fails;
  logic [31:0] lcg_state;

  mmio_top mmio_top_inst (.*);

  // Watches the host ports and compares every done pulse.
  mmio_checker checker_inst (.*);

  // Handshake rules on the internal channels.
  bind mmio_top mmio_assertions assertions_inst (.*);

  always #10 clk = ~clk;

  // LCG step.
  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic logic [data_w-1:0] rand_data();
    logic [31:0] hi;
    hi = next_rand();
    return {hi, next_rand()};
  endfunction

  // Byte address of register index idx.
  function automatic logic [addr_w-1:0] map_addr(input logic [1:0] idx);
    return {27'd0, idx, 3'd0};
  endfunction

  // Unaligned inside the map or anywhere outside it.
  function automatic logic [addr_w-1:0] bad_addr(input logic [31:0] r);
    logic [addr_w-1:0] a;
    if (r[31]) begin
      a = {27'd0, r[20:16]};
      if (a[2:0] == 3'd0)
        a[0] = 1'b1;
    end else begin
      a = r;
      if (a[31:5] == 27'd0)
        a[12] = 1'b1;
    end
    return a;
  endfunction

  // Mostly mapped registers with about one in eight an error address.
  function automatic logic [addr_w-1:0] pick_addr();
    logic [31:0] r;
    r = next_rand();
    if (r[31:29] == 3'd0)
      return bad_addr(next_rand());
    return map_addr(r[17:16]);
  endfunction

  // Inputs change 1 ns after the rising edge.
  task automatic step();
    @(posedge clk);
    #1;
  endtask

  task automatic wait_idle(input string what);
    int n;
    n = 0;
    while ((rd_busy || wr_busy) && n < op_limit) begin
      step();
      n++;
    end
    if (rd_busy || wr_busy) begin
      $display("Timeout at %0t: %s did not complete", $time, what);
      timeouts++;
    end
  endtask

  task automatic read_reg(input logic [addr_w-1:0] addr);
    wait_idle("command before a read");
    rd_addr = addr;
    rd_req  = 1'b1;
    step();
    rd_req  = 1'b0;
    wait_idle("read");
  endtask

  task automatic write_reg(input logic [addr_w-1:0] addr, input logic [data_w-1:0] data);
    wait_idle("command before a write");
    wr_addr = addr;
    wr_data = data;
    wr_req  = 1'b1;
    step();
    wr_req  = 1'b0;
    wait_idle("write");
  endtask

  // Read and write of one address strobed on the same edge.
  task automatic read_write_same(input logic [addr_w-1:0] addr, input logic [data_w-1:0] data);
    wait_idle("command before a paired read and write");
    rd_addr = addr;
    wr_addr = addr;
    wr_data = data;
    rd_req  = 1'b1;
    wr_req  = 1'b1;
    step();
    rd_req  = 1'b0;
    wr_req  = 1'b0;
    wait_idle("paired read and write");
  endtask

  // Overlapping reads and writes where each is issued when its channel is free.
  task automatic run_mix();
    int          issued;
    int          cycles;
    logic [31:0] r;
    issued = 0;
    cycles = 0;
    while (issued < mix_total && cycles < mix_limit) begin
      r = next_rand();
      if (r[31] && !rd_busy) begin
        rd_addr = pick_addr();
        rd_req  = 1'b1;
        issued++;
      end
      if (r[30] && !wr_busy && issued < mix_total) begin
        wr_addr = pick_addr();
        wr_data = rand_data();
        wr_req  = 1'b1;
        issued++;
      end
      step();
      rd_req = 1'b0;
      wr_req = 1'b0;
      cycles++;
    end
    if (issued < mix_total) begin
      $display("Timeout at %0t: only %0d of %0d mixed commands issued", $time, issued, mix_total);
      timeouts++;
    end
    wait_idle("last mixed command");
  endtask

  initial begin
    logic [31:0] r;
    clk          = 1'b0;
    rst          = 1'b1;
    rd_req       = 1'b0;
    rd_addr      = '0;
    wr_req       = 1'b0;
    wr_addr      = '0;
    wr_data      = '0;
    lcg_state    = 32'h792a;
    timeouts     = 0;
    assert_fails = 0;
    repeat (5) @(posedge clk);
    #1;
    rst = 1'b0;

    // Reset values of all four registers.
    for (int i = 0; i < 4; i++)
      read_reg(map_addr(2'(i)));

    // Scratch writes with readback and then the counter.
    repeat (20) begin
      r = next_rand();
      write_reg(map_addr(r[31] ? 2'd2 : 2'd1), rand_data());
      if (r[29])
        read_reg(map_addr(r[28] ? 2'd2 : 2'd1));
    end
    for (int i = 1; i < 4; i++)
      read_reg(map_addr(2'(i)));

    // Read-only targets.
    write_reg(map_addr(2'd0), rand_data());
    write_reg(map_addr(2'd3), rand_data());
    read_reg(map_addr(2'd0));
    read_reg(map_addr(2'd3));

    // Error addresses.
    repeat (12) begin
      read_reg(bad_addr(next_rand()));
      write_reg(bad_addr(next_rand()), rand_data());
    end
    for (int i = 0; i < 4; i++)
      read_reg(map_addr(2'(i)));

    // Read returns the old value when a write lands on the same edge.
    repeat (8) begin
      r = next_rand();
      read_write_same(map_addr(r[31] ? 2'd2 : 2'd1), rand_data());
    end
    for (int i = 1; i < 4; i++)
      read_reg(map_addr(2'(i)));

    run_mix();
    step();

    assert_fails = mmio_top_inst.assertions_inst.fail_count;
    $display("Summary: %0d reads, %0d writes, %0d errors, %0d asserts, %0d timeouts, %0d open",
             reads_checked, writes_checked, err_count, assert_fails, timeouts, pending);
    if (err_count == 0 && assert_fails == 0 && timeouts == 0 && pending == 0)
      $display("All tests passed!");
    else
      $display("Test failures found");
    $finish;
  end

endmodule

//--- verilog/mmio_decode.sv
// MMIO decode: slave channel acceptance and address decode into register operations.
`timescale 1ns/1ps

module mmio_decode (
  input  logic                        clk,
  input  logic                        rst,

  // Read address channel.
  input  logic                        arvalid,
  output logic                        arready,
  input  logic [mmio_pkg::addr_w-1:0] araddr,

  // Write address and write data channels.
  input  logic                        awvalid,
  output logic                        awready,
  input  logic [mmio_pkg::addr_w-1:0] awaddr,
  input  logic                        wvalid,
  output logic                        wready,
  input  logic [mmio_pkg::data_w-1:0] wdata,

  // Result slot status.
  input  logic                        rd_slot_free,
  input  logic                        wr_slot_free,

  // Decoded operations.
  output logic                        rd_op,
  output mmio_pkg::reg_sel_t          rd_sel,
  output logic                        rd_err,
  output logic                        wr_op,
  output mmio_pkg::reg_sel_t          wr_sel,
  output logic [mmio_pkg::data_w-1:0] wr_data_q,
  output logic                        wr_err
);

  import mmio_pkg::*;

  reg_sel_t ar_sel;
  logic     ar_err;
  reg_sel_t aw_sel;
  logic     aw_err;
  logic     wr_accept;

  // Map a byte address to a register index.
  // Unaligned and unmapped addresses both miss every case.
  function automatic void decode_addr(input logic [addr_w-1:0] addr,
                                      output reg_sel_t sel, output logic err);
    sel = sel_id;
    err = 1'b0;
    case (addr)
      reg_id_addr:       sel = sel_id;
      reg_scratch0_addr: sel = sel_scratch0;
      reg_scratch1_addr: sel = sel_scratch1;
      reg_wr_count_addr: sel = sel_wr_count;
      default:           err = 1'b1;
    endcase
  endfunction

  always_comb begin
    decode_addr(araddr, ar_sel, ar_err);
    decode_addr(awaddr, aw_sel, aw_err);
  end

  // The read result slot lets one read through at a time.
  assign arready = rd_slot_free && !rd_op;

  // Address and data are taken as one pair.
  assign wr_accept = awvalid && wvalid && wr_slot_free && !wr_op;
  assign awready   = wr_accept;
  assign wready    = wr_accept;

  // Op strobes follow the handshake by one cycle.
  always_ff @(posedge clk) begin
    if (rst) begin
      rd_op <= 1'b0;
      wr_op <= 1'b0;
    end else begin
      rd_op <= arvalid && arready;
      wr_op <= wr_accept;
    end
  end

  // Op payload.
  always_ff @(posedge clk) begin
    if (arvalid && arready) begin
      rd_sel <= ar_sel;
      rd_err <= ar_err;
    end
    if (wr_accept) begin
      wr_sel    <= aw_sel;
      wr_err    <= aw_err;
      wr_data_q <= wdata;
    end
  end

endmodule

//--- verilog/mmio_execute.sv
// MMIO execute: register bank performing decoded reads and writes and forming responses.
`timescale 1ns/1ps

module mmio_execute (
  input  logic                        clk,
  input  logic                        rst,

  // Decoded operations.
  input  logic                        rd_op,
  input  mmio_pkg::reg_sel_t          rd_sel,
  input  logic                        rd_err,
  input  logic                        wr_op,
  input  mmio_pkg::reg_sel_t          wr_sel,
  input  logic [mmio_pkg::data_w-1:0] wr_data_q,
  input  logic                        wr_err,

  // Responses towards the result slots.
  output logic                        rd_load,
  output mmio_pkg::rd_resp_t          rd_payload,
  output logic                        wr_load,
  output mmio_pkg::wr_resp_t          wr_payload
);

  import mmio_pkg::*;

  logic [data_w-1:0] scratch0;
  logic [data_w-1:0] scratch1;
  logic [data_w-1:0] wr_count;
  logic [data_w-1:0] rd_value;
  logic [resp_w-1:0] wr_code;

  // Combinational read mux.
  // A write in the same cycle commits only at the edge, so reads see old values.
  always_comb begin
    case (rd_sel)
      sel_id:       rd_value = id_value;
      sel_scratch0: rd_value = scratch0;
      sel_scratch1: rd_value = scratch1;
      default:      rd_value = wr_count;
    endcase
  end

  // Read response with zero data on a decode error.
  always_comb begin
    rd_payload.data = rd_err ? '0 : rd_value;
    rd_payload.resp = rd_err ? resp_decerr : resp_okay;
  end

  // Write response.
  // Identity and counter are read-only.
  always_comb begin
    if (wr_err)
      wr_code = resp_decerr;
    else if (wr_sel == sel_id || wr_sel == sel_wr_count)
      wr_code = resp_slverr;
    else
      wr_code = resp_okay;
    wr_payload.resp = wr_code;
  end

  // Each op loads its result slot in the same cycle.
  assign rd_load = rd_op;
  assign wr_load = wr_op;

  // Register bank.
  // Only okay writes change state and bump the counter.
  always_ff @(posedge clk) begin
    if (rst) begin
      scratch0 <= '0;
      scratch1 <= '0;
      wr_count <= '0;
    end else if (wr_op && wr_code == resp_okay) begin
      if (wr_sel == sel_scratch0)
        scratch0 <= wr_data_q;
      if (wr_sel == sel_scratch1)
        scratch1 <= wr_data_q;
      wr_count <= wr_count + data_w'(1);
    end
  end

endmodule

//--- verilog/mmio_master.sv
// MMIO master: host read and write commands bridged onto AXI-lite channels.
`timescale 1ns/1ps

module mmio_master (
  input  logic                        clk,
  input  logic                        rst,

  // Host read command and completion.
  input  logic                        rd_req,
  input  logic [mmio_pkg::addr_w-1:0] rd_addr,
  output logic                        rd_busy,
  output logic                        rd_done,
  output logic [mmio_pkg::data_w-1:0] rd_data,
  output logic [mmio_pkg::resp_w-1:0] rd_resp,

  // Host write command and completion.
  input  logic                        wr_req,
  input  logic [mmio_pkg::addr_w-1:0] wr_addr,
  input  logic [mmio_pkg::data_w-1:0] wr_data,
  output logic                        wr_busy,
  output logic                        wr_done,
  output logic [mmio_pkg::resp_w-1:0] wr_resp,

  // Read address and read data channels.
  output logic                        arvalid,
  input  logic                        arready,
  output logic [mmio_pkg::addr_w-1:0] araddr,
  input  logic                        rvalid,
  output logic                        rready,
  input  logic [mmio_pkg::data_w-1:0] rdata,
  input  logic [mmio_pkg::resp_w-1:0] rresp,

  // Write address, write data and write response channels.
  output logic                        awvalid,
  input  logic                        awready,
  output logic [mmio_pkg::addr_w-1:0] awaddr,
  output logic                        wvalid,
  input  logic                        wready,
  output logic [mmio_pkg::data_w-1:0] wdata,
  input  logic                        bvalid,
  output logic                        bready,
  input  logic [mmio_pkg::resp_w-1:0] bresp
);

  logic rd_start;
  logic wr_start;

  // Responses are always accepted.
  assign rready = 1'b1;
  assign bready = 1'b1;

  // Busy covers the whole transfer, so it also means the channel is idle.
  assign rd_start = rd_req && !rd_busy;
  // No new write while aw, w or b is still outstanding.
  assign wr_start = wr_req && !wr_busy;

  // Read control.
  always_ff @(posedge clk) begin
    if (rst) begin
      arvalid <= 1'b0;
      rd_busy <= 1'b0;
      rd_done <= 1'b0;
    end else begin
      rd_done <= rvalid && rready;
      if (arvalid && arready)
        arvalid <= 1'b0;
      if (rvalid && rready)
        rd_busy <= 1'b0;
      if (rd_start) begin
        arvalid <= 1'b1;
        rd_busy <= 1'b1;
      end
    end
  end

  // Read payload takes the address on start and the response on handshake.
  always_ff @(posedge clk) begin
    if (rd_start)
      araddr <= rd_addr;
    if (rvalid && rready) begin
      rd_data <= rdata;
      rd_resp <= rresp;
    end
  end

  // Write control.
  // aw and w rise together and each drops on its own handshake.
  always_ff @(posedge clk) begin
    if (rst) begin
      awvalid <= 1'b0;
      wvalid  <= 1'b0;
      wr_busy <= 1'b0;
      wr_done <= 1'b0;
    end else begin
      wr_done <= bvalid && bready;
      if (awvalid && awready)
        awvalid <= 1'b0;
      if (wvalid && wready)
        wvalid <= 1'b0;
      if (bvalid && bready)
        wr_busy <= 1'b0;
      if (wr_start) begin
        awvalid <= 1'b1;
        wvalid  <= 1'b1;
        wr_busy <= 1'b1;
      end
    end
  end

  // Write payload.
  always_ff @(posedge clk) begin
    if (wr_start) begin
      awaddr <= wr_addr;
      wdata  <= wr_data;
    end
    if (bvalid && bready)
      wr_resp <= bresp;
  end

endmodule

//--- verilog/mmio_pkg.sv
// MMIO package: bus widths, response codes, register map, register index and response payloads.
package mmio_pkg;

  // Bus widths.
  localparam int addr_w = 32;
  localparam int data_w = 64;
  localparam int resp_w = 2;

  // AXI-lite response codes.
  localparam logic [resp_w-1:0] resp_okay   = 2'd0;
  localparam logic [resp_w-1:0] resp_slverr = 2'd2;
  localparam logic [resp_w-1:0] resp_decerr = 2'd3;

  // Register byte addresses.
  // Every register is 8 bytes wide, so the low three bits must be zero.
  localparam logic [addr_w-1:0] reg_id_addr       = 32'h0000_0000;
  localparam logic [addr_w-1:0] reg_scratch0_addr = 32'h0000_0008;
  localparam logic [addr_w-1:0] reg_scratch1_addr = 32'h0000_0010;
  localparam logic [addr_w-1:0] reg_wr_count_addr = 32'h0000_0018;

  // Constant returned by the identity register.
  // ASCII "MMIO" followed by a version field.
  localparam logic [data_w-1:0] id_value = 64'h4d4d_494f_0001_0000;

  // Register index after decode.
  typedef enum logic [1:0] {
    sel_id       = 2'd0,
    sel_scratch0 = 2'd1,
    sel_scratch1 = 2'd2,
    sel_wr_count = 2'd3
  } reg_sel_t;

  // Read response payload.
  // Data sits in the upper bits, the response code in the lowest two.
  typedef struct packed {
    logic [data_w-1:0] data;
    logic [resp_w-1:0] resp;
  } rd_resp_t;

  // Write response payload.
  // Only the response code travels back on the b channel.
  typedef struct packed {
    logic [resp_w-1:0] resp;
  } wr_resp_t;

endpackage

//--- verilog/mmio_result.sv
// MMIO result: single holding slot driving one response channel, parameterized by payload.
`timescale 1ns/1ps

module mmio_result #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     rst,

  // From execute.
  input  logic     load,
  input  payload_t payload_in,

  // Response channel.
  output logic     valid,
  input  logic     ready,
  output payload_t payload,

  // Slot empty and not about to fill.
  output logic     free
);

  // Valid rises one cycle after load and holds until the handshake.
  always_ff @(posedge clk) begin
    if (rst)
      valid <= 1'b0;
    else if (load)
      valid <= 1'b1;
    else if (valid && ready)
      valid <= 1'b0;
  end

  // Payload stays stable while valid is high.
  always_ff @(posedge clk) begin
    if (load)
      payload <= payload_in;
  end

  // Decode uses this to hold off the next request.
  assign free = !valid && !load;

endmodule

//--- verilog/mmio_top.sv
// MMIO top: bridge, decode, execute and the two response slots wired together.
`timescale 1ns/1ps

module mmio_top (
  input  logic                        clk,
  input  logic                        rst,

  // Host read side.
  input  logic                        rd_req,
  input  logic [mmio_pkg::addr_w-1:0] rd_addr,
  output logic                        rd_busy,
  output logic                        rd_done,
  output logic [mmio_pkg::data_w-1:0] rd_data,
  output logic [mmio_pkg::resp_w-1:0] rd_resp,

  // Host write side.
  input  logic                        wr_req,
  input  logic [mmio_pkg::addr_w-1:0] wr_addr,
  input  logic [mmio_pkg::data_w-1:0] wr_data,
  output logic                        wr_busy,
  output logic                        wr_done,
  output logic [mmio_pkg::resp_w-1:0] wr_resp
);

  import mmio_pkg::*;

  // AXI-lite channels.
  logic              arvalid;
  logic              arready;
  logic [addr_w-1:0] araddr;
  logic              rvalid;
  logic              rready;
  logic [data_w-1:0] rdata;
  logic [resp_w-1:0] rresp;
  logic              awvalid;
  logic              awready;
  logic [addr_w-1:0] awaddr;
  logic              wvalid;
  logic              wready;
  logic [data_w-1:0] wdata;
  logic              bvalid;
  logic              bready;
  logic [resp_w-1:0] bresp;

  // Decoded operations.
  logic              rd_op;
  reg_sel_t          rd_sel;
  logic              rd_err;
  logic              wr_op;
  reg_sel_t          wr_sel;
  logic [data_w-1:0] wr_data_q;
  logic              wr_err;

  // Execute to result slots.
  logic              rd_load;
  rd_resp_t          rd_payload;
  logic              wr_load;
  wr_resp_t          wr_payload;
  logic              rd_slot_free;
  logic              wr_slot_free;
  rd_resp_t          r_payload;
  wr_resp_t          b_payload;

  // Unpack the held payloads onto the response channels.
  assign rdata = r_payload.data;
  assign rresp = r_payload.resp;
  assign bresp = b_payload.resp;

  mmio_master mmio_master_inst (
    .clk     (clk),     .rst     (rst),
    .rd_req  (rd_req),  .rd_addr (rd_addr), .rd_busy (rd_busy),
    .rd_done (rd_done), .rd_data (rd_data), .rd_resp (rd_resp),
    .wr_req  (wr_req),  .wr_addr (wr_addr), .wr_data (wr_data),
    .wr_busy (wr_busy), .wr_done (wr_done), .wr_resp (wr_resp),
    .arvalid (arvalid), .arready (arready), .araddr  (araddr),
    .rvalid  (rvalid),  .rready  (rready),  .rdata   (rdata),   .rresp (rresp),
    .awvalid (awvalid), .awready (awready), .awaddr  (awaddr),
    .wvalid  (wvalid),  .wready  (wready),  .wdata   (wdata),
    .bvalid  (bvalid),  .bready  (bready),  .bresp   (bresp)
  );

  mmio_decode mmio_decode_inst (
    .clk          (clk),          .rst          (rst),
    .arvalid      (arvalid),      .arready      (arready),      .araddr (araddr),
    .awvalid      (awvalid),      .awready      (awready),      .awaddr (awaddr),
    .wvalid       (wvalid),       .wready       (wready),       .wdata  (wdata),
    .rd_slot_free (rd_slot_free), .wr_slot_free (wr_slot_free),
    .rd_op        (rd_op),        .rd_sel       (rd_sel),       .rd_err (rd_err),
    .wr_op        (wr_op),        .wr_sel       (wr_sel),
    .wr_data_q    (wr_data_q),    .wr_err       (wr_err)
  );

  mmio_execute mmio_execute_inst (
    .clk        (clk),        .rst        (rst),
    .rd_op      (rd_op),      .rd_sel     (rd_sel),     .rd_err (rd_err),
    .wr_op      (wr_op),      .wr_sel     (wr_sel),
    .wr_data_q  (wr_data_q),  .wr_err     (wr_err),
    .rd_load    (rd_load),    .rd_payload (rd_payload),
    .wr_load    (wr_load),    .wr_payload (wr_payload)
  );

  // Read response slot drives the r channel.
  mmio_result #(.payload_t(rd_resp_t)) rd_result_inst (
    .clk     (clk),        .rst   (rst),
    .load    (rd_load),    .payload_in (rd_payload),
    .valid   (rvalid),     .ready (rready),
    .payload (r_payload),  .free  (rd_slot_free)
  );

  // Write response slot drives the b channel.
  mmio_result #(.payload_t(wr_resp_t)) wr_result_inst (
    .clk     (clk),        .rst   (rst),
    .load    (wr_load),    .payload_in (wr_payload),
    .valid   (bvalid),     .ready (bready),
    .payload (b_payload),  .free  (wr_slot_free)
  );

endmodule
